//--- rtl/datapathPkg.sv
package datapathPkg;

    localparam int wordWidth  = 32;
    localparam int numGenRegs = 16;
    localparam int constWidth = 19;   // IR[18:0]

    // one data word on the internal bus
    typedef logic [wordWidth-1:0] wordT;

    // ALU result and Z register, low word in the lower half
    typedef logic [2*wordWidth-1:0] dwordT;

    // one strobe per general register R0..R15
    typedef logic [numGenRegs-1:0] regMaskT;

    // immediate field taken from the instruction register
    typedef logic [constWidth-1:0] constFieldT;

endpackage

//--- rtl/aluPkg.sv
package aluPkg;

    // operation codes seen on the operation port
    typedef enum logic [4:0] {
        opAdd  = 5'b00011,
        opSub  = 5'b00100,
        opShr  = 5'b00101,
        opShl  = 5'b00110,
        opShra = 5'b00111,
        opRor  = 5'b01000,
        opRol  = 5'b01001,
        opAnd  = 5'b01010,
        opOr   = 5'b01011,
        opMul  = 5'b01110,
        opDiv  = 5'b01111,
        opNeg  = 5'b10000,
        opNot  = 5'b10001
    } aluOpT;

    // shift and rotate count, low bits of the bus
    typedef logic [4:0] shiftAmtT;

endpackage

//--- rtl/memoryInterface.sv
`timescale 1ns/1ps

module memoryInterface (
    input  logic              clock,
    input  logic              arstN,
    input  logic              mdrIn,
    input  logic              read,
    input  logic              marIn,
    input  datapathPkg::wordT busValue,
    input  datapathPkg::wordT mdataIn,
    output datapathPkg::wordT mdrValue,
    output datapathPkg::wordT memAddress
);
    import datapathPkg::*;

    wordT mdrNext;

    // memory data wins over the bus while read is raised
    assign mdrNext = read ? mdataIn : busValue;

    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            mdrValue <= '0;
        end else if (mdrIn) begin
            mdrValue <= mdrNext;
        end
    end

    // MAR feeds the address port directly
    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            memAddress <= '0;
        end else if (marIn) begin
            memAddress <= busValue;   // address taken straight off the bus
        end
    end

endmodule

//--- rtl/registerFile.sv
`timescale 1ns/1ps

module registerFile (
    input  logic                 clock,
    input  logic                 arstN,
    input  datapathPkg::regMaskT regIn,
    input  datapathPkg::regMaskT regOut,
    input  logic                 hiIn,
    input  logic                 hiOut,
    input  logic                 loIn,
    input  logic                 loOut,
    input  datapathPkg::wordT    busValue,
    output datapathPkg::wordT    regBusValue,
    output logic                 regDriving
);
    import datapathPkg::*;

    // R0..R15 followed by HI and LO
    localparam int numRegs = numGenRegs + 2;

    wordT             regs [numRegs];
    logic [numRegs-1:0] loadMask;
    logic [numRegs-1:0] driveMask;

    // HI sits just above R15, LO above HI, so index order is the priority order
    assign loadMask  = {loIn, hiIn, regIn};
    assign driveMask = {loOut, hiOut, regOut};

    for (genvar i = 0; i < numRegs; i++) begin : gReg
        always_ff @(posedge clock or negedge arstN) begin
            if (!arstN) begin
                regs[i] <= '0;
            end else if (loadMask[i]) begin
                regs[i] <= busValue;
            end
        end
    end

    // walk from the top so the lowest raised index is written last
    always_comb begin
        regBusValue = '0;
        for (int i = numRegs - 1; i >= 0; i--) begin
            if (driveMask[i]) begin
                regBusValue = regs[i];
            end
        end
    end

    assign regDriving = |driveMask;   // any general, HI or LO out strobe

endmodule

//--- rtl/specialRegs.sv
`timescale 1ns/1ps

module specialRegs #(
    parameter datapathPkg::wordT resetPc = '0
) (
    input  logic               clock,
    input  logic               arstN,
    input  logic               pcIn,
    input  logic               irIn,
    input  logic               yIn,
    input  logic               zIn,
    input  datapathPkg::wordT  busValue,
    input  datapathPkg::dwordT aluResult,
    output datapathPkg::wordT  pcValue,
    output datapathPkg::wordT  yValue,
    output datapathPkg::wordT  constValue,
    output datapathPkg::dwordT zValue
);
    import datapathPkg::*;

    wordT       ir;
    constFieldT constField;

    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            pcValue <= resetPc;
        end else if (pcIn) begin
            pcValue <= busValue;
        end
    end

    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            ir     <= '0;
            yValue <= '0;
        end else begin
            if (irIn) ir <= busValue;
            if (yIn) yValue <= busValue;   // first ALU operand
        end
    end

    // full 64-bit result, mul and div fill both halves
    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            zValue <= '0;
        end else if (zIn) begin
            zValue <= aluResult;
        end
    end

    assign constField = ir[constWidth-1:0];
    assign constValue = {{(wordWidth - constWidth){constField[constWidth-1]}}, constField};

endmodule

//--- rtl/alu.sv
`timescale 1ns/1ps

module alu (
    input  datapathPkg::wordT  yValue,
    input  datapathPkg::wordT  busValue,
    input  aluPkg::aluOpT      operation,
    input  logic               incPc,
    output datapathPkg::dwordT aluResult
);
    import datapathPkg::*;
    import aluPkg::*;

    shiftAmtT shiftAmt;
    dwordT    rotPair;
    dwordT    rotRight;
    dwordT    rotLeft;
    dwordT    product;
    wordT     quotient;
    wordT     remainder;
    logic     divByZero;
    wordT     wordResult;

    assign shiftAmt = shiftAmtT'(busValue);   // only the low five bits count

    // rotate by shifting a doubled copy of Y
    assign rotPair  = {yValue, yValue};
    assign rotRight = rotPair >> shiftAmt;
    assign rotLeft  = rotPair << shiftAmt;

    // signed operands extend to 64 bits before the multiply
    assign product = $signed(yValue) * $signed(busValue);

    assign divByZero = (busValue == '0);

    always_comb begin
        if (divByZero) begin
            quotient  = '1;
            remainder = yValue;   // dividend passes through
        end else begin
            quotient  = $signed(yValue) / $signed(busValue);
            remainder = $signed(yValue) % $signed(busValue);   // sign follows dividend
        end
    end

    // Y is the left operand of single-word operations
    always_comb begin
        case (operation)
            opAdd:   wordResult = yValue + busValue;
            opSub:   wordResult = yValue - busValue;
            opShr:   wordResult = yValue >> shiftAmt;
            opShl:   wordResult = yValue << shiftAmt;
            opShra:  wordResult = $signed(yValue) >>> shiftAmt;
            opRor:   wordResult = rotRight[wordWidth-1:0];
            opRol:   wordResult = rotLeft[2*wordWidth-1:wordWidth];
            opAnd:   wordResult = yValue & busValue;
            opOr:    wordResult = yValue | busValue;
            opNeg:   wordResult = -busValue;   // unary ops work on the bus
            opNot:   wordResult = ~busValue;
            default: wordResult = '0;
        endcase
    end

    always_comb begin
        if (incPc) begin
            aluResult = dwordT'(wordT'(busValue + 1'b1));   // PC increment during fetch
        end else begin
            case (operation)
                opMul:   aluResult = product;
                opDiv:   aluResult = {remainder, quotient};
                default: aluResult = dwordT'(wordResult);   // Z high cleared
            endcase
        end
    end

endmodule

//--- rtl/busMux.sv
`timescale 1ns/1ps

module busMux (
    input  logic               mdrOut,
    input  logic               pcOut,
    input  logic               zLowOut,
    input  logic               zHighOut,
    input  logic               cOut,
    input  logic               regDriving,
    input  datapathPkg::wordT  mdrValue,
    input  datapathPkg::wordT  pcValue,
    input  datapathPkg::wordT  constValue,
    input  datapathPkg::wordT  regBusValue,
    input  datapathPkg::dwordT zValue,
    output datapathPkg::wordT  busValue
);
    import datapathPkg::*;

    wordT zLow;
    wordT zHigh;

    assign {zHigh, zLow} = zValue;

    // fixed priority, register file group resolved internally
    always_comb begin
        if (mdrOut) begin
            busValue = mdrValue;
        end else if (pcOut) begin
            busValue = pcValue;
        end else if (zLowOut) begin
            busValue = zLow;
        end else if (zHighOut) begin
            busValue = zHigh;
        end else if (cOut) begin
            busValue = constValue;   // sign-extended IR field
        end else if (regDriving) begin
            busValue = regBusValue;   // R0..R15, then HI, then LO
        end else begin
            busValue = '0;   // idle bus
        end
    end

endmodule

//--- rtl/datapath.sv
`timescale 1ns/1ps

module datapath #(
    parameter datapathPkg::wordT resetPc = '0
) (
    input  logic                 clock,
    input  logic                 arstN,
    input  datapathPkg::regMaskT regIn,
    input  datapathPkg::regMaskT regOut,
    input  logic                 hiIn,
    input  logic                 hiOut,
    input  logic                 loIn,
    input  logic                 loOut,
    input  logic                 pcIn,
    input  logic                 pcOut,
    input  logic                 irIn,
    input  logic                 mdrIn,
    input  logic                 mdrOut,
    input  logic                 marIn,
    input  logic                 yIn,
    input  logic                 zIn,
    input  logic                 zLowOut,
    input  logic                 zHighOut,
    input  logic                 read,
    input  logic                 incPc,
    input  logic                 cOut,
    input  datapathPkg::wordT    mdataIn,
    input  aluPkg::aluOpT        operation,
    output datapathPkg::wordT    busValue,
    output datapathPkg::wordT    memAddress
);
    import datapathPkg::*;

    wordT  mdrValue;
    wordT  regBusValue;
    wordT  pcValue;
    wordT  yValue;
    wordT  constValue;
    dwordT zValue;
    dwordT aluResult;
    logic  regDriving;

    memoryInterface u_memoryInterface (
        .clock      (clock),
        .arstN      (arstN),
        .mdrIn      (mdrIn),
        .read       (read),
        .marIn      (marIn),
        .busValue   (busValue),
        .mdataIn    (mdataIn),
        .mdrValue   (mdrValue),
        .memAddress (memAddress)
    );

    registerFile u_registerFile (
        .clock       (clock),
        .arstN       (arstN),
        .regIn       (regIn),
        .regOut      (regOut),
        .hiIn        (hiIn),
        .hiOut       (hiOut),
        .loIn        (loIn),
        .loOut       (loOut),
        .busValue    (busValue),
        .regBusValue (regBusValue),
        .regDriving  (regDriving)
    );

    specialRegs #(
        .resetPc (resetPc)
    ) u_specialRegs (
        .clock      (clock),
        .arstN      (arstN),
        .pcIn       (pcIn),
        .irIn       (irIn),
        .yIn        (yIn),
        .zIn        (zIn),
        .busValue   (busValue),
        .aluResult  (aluResult),
        .pcValue    (pcValue),
        .yValue     (yValue),
        .constValue (constValue),
        .zValue     (zValue)
    );

    alu u_alu (
        .yValue    (yValue),
        .busValue  (busValue),
        .operation (operation),
        .incPc     (incPc),
        .aluResult (aluResult)
    );

    busMux u_busMux (
        .mdrOut      (mdrOut),
        .pcOut       (pcOut),
        .zLowOut     (zLowOut),
        .zHighOut    (zHighOut),
        .cOut        (cOut),
        .regDriving  (regDriving),
        .mdrValue    (mdrValue),
        .pcValue     (pcValue),
        .constValue  (constValue),
        .regBusValue (regBusValue),
        .zValue      (zValue),
        .busValue    (busValue)
    );

endmodule

//--- tb/datapathTb.sv
`timescale 1ns/1ps

module datapathTb;
    import datapathPkg::*;
    import aluPkg::*;

    localparam int srcHi    = 16;   // codes past R15 for the strobe helpers
    localparam int srcLo    = 17;
    localparam int srcPc    = 18;
    localparam int srcZLow  = 19;
    localparam int srcZHigh = 20;
    localparam int srcMdr   = 21;
    localparam int srcConst = 22;
    localparam int aluRounds = 3;
    localparam int timeoutCycles = 2000;   // tests need roughly 480 cycles

    logic    clock;
    logic    arstN;
    regMaskT regIn;
    regMaskT regOut;
    logic    hiIn;
    logic    hiOut;
    logic    loIn;
    logic    loOut;
    logic    pcIn;
    logic    pcOut;
    logic    irIn;
    logic    mdrIn;
    logic    mdrOut;
    logic    marIn;
    logic    yIn;
    logic    zIn;
    logic    zLowOut;
    logic    zHighOut;
    logic    read;
    logic    incPc;
    logic    cOut;
    wordT    mdataIn;
    aluOpT   operation;
    wordT    busValue;
    wordT    memAddress;

    int          cycleCount;
    int          checkCount;
    int          errorCount;
    int          testCount;

    datapath u_dut (.*);

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;   // 4 ns period
    end

    initial begin
        cycleCount = 0;
        while (cycleCount < timeoutCycles) begin
            @(posedge clock);
            cycleCount++;
        end
        $display("timeout: run did not finish within %0d cycles", timeoutCycles);
        $display("tests failed");
        $finish;
    end

    task automatic stepCycle();
        @(posedge clock);
        #1;   // drive point
    endtask

    task automatic clearStrobes();
        regIn  = '0;
        regOut = '0;
        {hiIn, hiOut, loIn, loOut, pcIn, pcOut, irIn} = '0;
        {mdrIn, mdrOut, marIn, yIn, zIn, zLowOut, zHighOut} = '0;
        {read, incPc, cOut} = '0;
    endtask

    function automatic string srcName(input int src);
        case (src)
            srcHi:    return "HI";
            srcLo:    return "LO";
            srcPc:    return "PC";
            srcZLow:  return "Zlow";
            srcZHigh: return "Zhigh";
            srcMdr:   return "MDR";
            srcConst: return "C";
            default:  return $sformatf("R%0d", src);
        endcase
    endfunction

    task automatic setOut(input int src);
        case (src)
            srcHi:    hiOut = 1'b1;
            srcLo:    loOut = 1'b1;
            srcPc:    pcOut = 1'b1;
            srcZLow:  zLowOut = 1'b1;
            srcZHigh: zHighOut = 1'b1;
            srcMdr:   mdrOut = 1'b1;
            srcConst: cOut = 1'b1;
            default:  regOut[src[3:0]] = 1'b1;
        endcase
    endtask

    task automatic setIn(input int dst);
        case (dst)
            srcHi:   hiIn = 1'b1;
            srcLo:   loIn = 1'b1;
            srcPc:   pcIn = 1'b1;
            default: regIn[dst[3:0]] = 1'b1;
        endcase
    endtask

    task automatic checkWord(input string name, input wordT got, input wordT exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("error %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic checkDword(input string name, input dwordT got, input dwordT exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("error %s: got low %h high %h, expected low %h high %h",
                     name, got[31:0], got[63:32], exp[31:0], exp[63:32]);
        end
    endtask

    task automatic checkAddress(input wordT got, input wordT exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("error memAddress: got %h, expected %h", got, exp);
        end
    endtask

    task automatic endTest(input string name, input int startErrors);
        testCount++;
        $display("test %s finished with %0d errors", name, errorCount - startErrors);
    endtask

    // two out strobes raised together
    task automatic readPair(input int srcA, input int srcB, output wordT value);
        setOut(srcA);
        setOut(srcB);
        #2;
        value = busValue;
        stepCycle();
        clearStrobes();
    endtask

    task automatic readReg(input int src, output wordT value);
        readPair(src, src, value);
    endtask

    task automatic loadReg(input int dst, input wordT value);
        mdataIn = value;
        read    = 1'b1;
        mdrIn   = 1'b1;
        stepCycle();
        clearStrobes();
        setOut(srcMdr);
        setIn(dst);
        stepCycle();
        clearStrobes();
    endtask

    // R2 into Y then R3 on the bus with the result into Z
    task automatic runOp(input aluOpT op, input wordT a, input wordT b);
        loadReg(2, a);
        loadReg(3, b);
        regOut[2] = 1'b1;
        yIn       = 1'b1;
        stepCycle();
        clearStrobes();
        regOut[3] = 1'b1;
        operation = op;
        zIn       = 1'b1;
        stepCycle();
        clearStrobes();
    endtask

    task automatic readZ(output dwordT z);
        wordT lo;
        wordT hi;
        readReg(srcZLow, lo);
        readReg(srcZHigh, hi);
        z = {hi, lo};
    endtask

    function automatic wordT wordModel(input aluOpT op, input wordT a, input wordT b);
        int n;
        n = int'(b[4:0]);
        case (op)
            opAdd:   return a + b;
            opSub:   return a - b;
            opShr:   return a >> n;
            opShl:   return a << n;
            opShra:  return $signed(a) >>> n;
            opRor:   return (a >> n) | (a << (32 - n));
            opRol:   return (a << n) | (a >> (32 - n));
            opAnd:   return a & b;
            opOr:    return a | b;
            opNeg:   return ~b + 32'd1;
            opNot:   return ~b;
            default: return '0;
        endcase
    endfunction

    function automatic dwordT mulModel(input wordT a, input wordT b);
        int sa;
        int sb;
        sa = a;
        sb = b;
        return longint'(sa) * longint'(sb);
    endfunction

    // remainder in the high word and quotient in the low word
    function automatic dwordT divModel(input wordT a, input wordT b);
        int sa;
        int sb;
        sa = a;
        sb = b;
        if (b == '0) return {a, 32'hffff_ffff};
        return {wordT'(sa % sb), wordT'(sa / sb)};
    endfunction

    task automatic checkZAndHiLo(input string name, input dwordT exp);
        dwordT z;
        wordT  hi;
        wordT  lo;
        readZ(z);
        checkDword({name, " Z"}, z, exp);
        zHighOut = 1'b1;
        hiIn     = 1'b1;
        stepCycle();
        clearStrobes();
        zLowOut = 1'b1;
        loIn    = 1'b1;
        stepCycle();
        clearStrobes();
        readReg(srcHi, hi);
        readReg(srcLo, lo);
        checkDword({name, " HI:LO"}, {hi, lo}, exp);
    endtask

    task automatic resetTest();
        int   startErrors;
        wordT value;
        startErrors = errorCount;
        for (int src = 0; src <= srcZHigh; src++) begin
            readReg(src, value);
            checkWord(srcName(src), value, '0);
        end
        endTest("resetValues", startErrors);
    endtask

    task automatic regLoadTest();
        int   startErrors;
        wordT expected [18];
        wordT value;
        startErrors = errorCount;
        for (int i = 0; i <= srcLo; i++) begin
            expected[i] = $urandom;
            loadReg(i, expected[i]);
        end
        for (int i = 0; i <= srcLo; i++) begin
            readReg(i, value);
            checkWord(srcName(i), value, expected[i]);
        end
        readPair(5, 9, value);
        checkWord("R5 over R9", value, expected[5]);
        readPair(3, srcHi, value);
        checkWord("R3 over HI", value, expected[3]);
        readPair(srcHi, srcLo, value);
        checkWord("HI over LO", value, expected[srcHi]);
        readPair(srcMdr, 0, value);   // MDR still holds the LO word
        checkWord("MDR over R0", value, expected[srcLo]);
        endTest("registerLoads", startErrors);
    endtask

    task automatic fetchTest();
        int   startErrors;
        wordT pcStart;
        wordT instr;
        wordT value;
        startErrors = errorCount;
        pcStart = $urandom & 32'h0000_ffff;
        loadReg(srcPc, pcStart);
        for (int n = 0; n < 2; n++) begin
            instr     = $urandom;
            instr[18] = (n == 0);   // negative constant first
            pcOut = 1'b1;
            marIn = 1'b1;
            incPc = 1'b1;
            zIn   = 1'b1;
            stepCycle();
            clearStrobes();
            zLowOut = 1'b1;
            pcIn    = 1'b1;
            stepCycle();
            clearStrobes();
            mdataIn = instr;
            read    = 1'b1;
            mdrIn   = 1'b1;
            stepCycle();
            clearStrobes();
            mdrOut = 1'b1;
            irIn   = 1'b1;
            stepCycle();
            clearStrobes();
            checkAddress(memAddress, pcStart);
            readReg(srcPc, value);
            checkWord("PC", value, pcStart + 32'd1);
            readReg(srcConst, value);
            checkWord("C", value, {{13{instr[18]}}, instr[18:0]});
            pcStart = pcStart + 32'd1;
        end
        endTest("fetch", startErrors);
    endtask

    task automatic aluTest();
        aluOpT ops [11] = '{opShra, opShr, opShl, opRor, opRol, opAdd,
                            opSub, opAnd, opOr, opNeg, opNot};
        int    startErrors;
        wordT  a;
        wordT  b;
        wordT  value;
        dwordT z;
        startErrors = errorCount;
        runOp(opShra, 32'hfff0_ffff, 32'd4);
        zLowOut   = 1'b1;
        regIn[1]  = 1'b1;
        stepCycle();
        clearStrobes();
        readReg(1, value);
        checkWord("R1 shra", value, 32'hffff_0fff);
        for (int i = 0; i < 11; i++) begin
            for (int r = 0; r < aluRounds; r++) begin
                a = $urandom;
                b = $urandom;
                runOp(ops[i], a, b);
                readZ(z);
                checkDword({"Z ", ops[i].name()}, z, {32'h0, wordModel(ops[i], a, b)});
            end
        end
        endTest("aluOps", startErrors);
    endtask

    task automatic mulDivTest();
        int   startErrors;
        wordT a;
        wordT b;
        startErrors = errorCount;
        for (int r = 0; r < aluRounds; r++) begin
            a = $urandom;
            b = $urandom;
            runOp(opMul, a, b);
            checkZAndHiLo($sformatf("mul %0d", r), mulModel(a, b));
            b = $urandom % 32'd2001 - 32'd1000;   // small signed divisor
            runOp(opDiv, a, b);
            checkZAndHiLo($sformatf("div %0d", r), divModel(a, b));
        end
        a = $urandom;
        runOp(opDiv, a, 32'd0);
        checkZAndHiLo("div by zero", {a, 32'hffff_ffff});
        endTest("mulDiv", startErrors);
    endtask

    initial begin
        void'($urandom(8));
        checkCount = 0;
        errorCount = 0;
        testCount  = 0;
        arstN      = 1'b0;
        mdataIn    = '0;
        operation  = opAdd;
        clearStrobes();
        repeat (8) @(posedge clock);
        #1;
        arstN = 1'b1;
        resetTest();
        regLoadTest();
        fetchTest();
        aluTest();
        mulDivTest();
        $display("summary: %0d tests, %0d checks, %0d errors", testCount, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

//--- compile.f
rtl/datapathPkg.sv
rtl/aluPkg.sv
rtl/memoryInterface.sv
rtl/registerFile.sv
rtl/specialRegs.sv
rtl/alu.sv
rtl/busMux.sv
rtl/datapath.sv
tb/datapathTb.sv

//--- run.sh
#!/usr/bin/env bash
# build the datapath testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
    --top-module datapathTb \
    -f compile.f \
    -o datapathSim

simOutput=$(./obj_dir/datapathSim)
echo "$simOutput"

if grep -qx "all tests passed" <<< "$simOutput"; then
    exit 0
fi
exit 1
